/* vlog.f */
+incdir+.
cimDataPkg.sv
cimCtrlPkg.sv
rowDriver.sv
macroSequencer.sv
tsColumn.sv
adcDecoder.sv
cimMacroTop.sv
tbCimMacro.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the CIM tile testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tbCimMacro -o simCimMacro

./obj_dir/simCimMacro > sim.log 2>&1
cat sim.log

# The log decides the outcome
if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"

/* tbCimMacro.sv */
//##########################################################
// CIM macro tile testbench
// Drives write, read and compute commands, checks them
// against a shadow weight array and reference sums
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "cim_config.svh"

module tbCimMacro;
    import cimDataPkg::*;
    import cimCtrlPkg::*;

    localparam int adcHalf     = 1 << (`NUM_ADC_BITS - 1);
    localparam int numComputes = 10;
    // Writes and reads of every row, saturation writes, plus the single computes
    localparam int numCmds     = 3 * `NUM_ROWS + numComputes + 6;
    // Reset, at most 8 cycles per command, and some slack
    localparam int maxCycles   = 16 + numCmds * 8 + 64;
    // Longest wait for any single response
    localparam int respLimit   = 12;

    logic    CLK = 1'b0;
    logic    rst;
    logic    cmdValid;
    cmdT     cmd;
    logic    busy;
    logic    rdValid;
    colDataT rdData;
    logic    resValid;
    adcVecT  result;

    // Shadow copy of the weight array
    colDataT shadow [`NUM_ROWS];
    // Outputs captured in the cycle their valid was seen
    colDataT rdSnap;
    adcVecT  resSnap;

    integer seed = 32'he1914cb3;
    int     errors = 0;
    int     checks = 0;
    int     testsRun = 0;
    int     testsBad = 0;
    int     testErrStart = 0;
    string  testName;
    int     cycleCount = 0;

    cimMacroTop cimMacroTop_i (
        .CLK      (CLK),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .busy     (busy),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .resValid (resValid),
        .result   (result)
    );

    // 8 ns period
    always #4 CLK = ~CLK;

    // Hard stop for a hung run
    always @(posedge CLK) begin : runLimit
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expv,
                              input logic [31:0] gotv);
        checks++;
        assert (gotv === expv) else begin
            $display("ERR %s expected 0x%0h got 0x%0h", name, expv, gotv);
            errors++;
        end
    endtask

    // Signed ADC code as a zero-padded word for hex printing
    function automatic logic [31:0] codeWord(input int code);
        return {{(32 - `NUM_ADC_BITS){1'b0}}, adcCodeT'(code)};
    endfunction

    // Sum of act x weight, arithmetic shift, clamp to the ADC range
    function automatic int expectedCode(input int col, input actVecT act);
        int sum;
        int actVal;
        int level;
        sum = 0;
        for (int i = 0; i < `NUM_ROWS; i++) begin
            if (act[i] == 2'b01) begin
                actVal = 1;
            end else if (act[i] == 2'b11) begin
                actVal = -1;
            end else begin
                actVal = 0;
            end
            // Stored 1 is weight +1, stored 0 is weight -1
            sum = sum + (shadow[i][col] ? actVal : -actVal);
        end
        level = sum >>> `NUM_ADC_REF_RANGE_SHIFTS;
        if (level > adcHalf - 1) begin
            level = adcHalf - 1;
        end else if (level < -adcHalf) begin
            level = -adcHalf;
        end
        return level;
    endfunction

    function automatic actVecT randomAct();
        actVecT a;
        for (int i = 0; i < `NUM_ROWS; i++) begin
            a[i] = actCodeT'($random(seed));
        end
        return a;
    endfunction

    // One-cycle strobe, then wait for the op's response
    task automatic runCommand(input cmdT c, output int doneAt, output int busyCycles);
        logic done;
        doneAt = 0;
        busyCycles = 0;
        @(posedge CLK);
        #1;
        cmdValid = 1'b1;
        cmd = c;
        @(posedge CLK);
        #1;
        cmdValid = 1'b0;
        for (int k = 1; k <= respLimit && doneAt == 0; k++) begin
            @(negedge CLK);
            if (busy) begin
                busyCycles++;
            end
            case (c.op)
                CMD_WRITE: done = !busy;
                CMD_READ:  done = rdValid;
                default:   done = resValid;
            endcase
            if (done) begin
                doneAt = k;
                rdSnap = rdData;
                resSnap = result;
            end
        end
        if (doneAt == 0) begin
            $display("Command %s got no response within %0d cycles", c.op.name(), respLimit);
            errors++;
        end else if (c.op == CMD_READ) begin
            // Pulse is a single cycle
            @(negedge CLK);
            checkValue("rdValid after pulse", 0, {31'd0, rdValid});
        end else if (c.op == CMD_COMPUTE) begin
            @(negedge CLK);
            checkValue("resValid after pulse", 0, {31'd0, resValid});
        end
    endtask

    task automatic writeRow(input int row, input colDataT data);
        cmdT c;
        int  doneAt;
        int  busyCycles;
        c = '0;
        c.op = CMD_WRITE;
        c.row = rowAddrT'(row);
        c.wrData = data;
        runCommand(c, doneAt, busyCycles);
        checkValue("busy cycles of write", 1, busyCycles);
        shadow[row] = data;
    endtask

    task automatic readRow(input int row);
        cmdT c;
        int  doneAt;
        int  busyCycles;
        c = '0;
        c.op = CMD_READ;
        c.row = rowAddrT'(row);
        runCommand(c, doneAt, busyCycles);
        checkValue("rdValid latency", 2, doneAt);
        checkValue("busy cycles of read", 1, busyCycles);
        checkValue($sformatf("rdData row %0d", row), 32'(shadow[row]), 32'(rdSnap));
    endtask

    task automatic computeCheck(input actVecT act);
        cmdT c;
        int  doneAt;
        int  busyCycles;
        c = '0;
        c.op = CMD_COMPUTE;
        c.act = act;
        runCommand(c, doneAt, busyCycles);
        checkValue("resValid latency", 4, doneAt);
        checkValue("busy cycles of compute", 3, busyCycles);
        for (int j = 0; j < `NUM_COLS; j++) begin
            checkValue($sformatf("result[%0d]", j), codeWord(expectedCode(j, act)),
                       codeWord(int'(resSnap[j])));
        end
    endtask

    // Every column of the last result against one fixed code
    task automatic expectAll(input int code);
        for (int j = 0; j < `NUM_COLS; j++) begin
            checkValue($sformatf("result[%0d]", j), codeWord(code), codeWord(int'(resSnap[j])));
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errors;
        testsRun++;
    endtask

    task automatic endTest();
        if (errors == testErrStart) begin
            $display("test %0d %s: ok", testsRun, testName);
        end else begin
            testsBad++;
            $display("test %0d %s: FAIL with %0d errors", testsRun, testName,
                     errors - testErrStart);
        end
    endtask

    initial begin : stimulus
        actVecT  act;
        int      row;
        colDataT newData;
        int      busyCycles;
        int      pulses;
        int      firstAt;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmd = '0;
        repeat (16) @(posedge CLK);
        #1;
        rst = 1'b0;

        startTest("reset state");
        @(negedge CLK);
        checkValue("busy", 0, {31'd0, busy});
        checkValue("rdValid", 0, {31'd0, rdValid});
        checkValue("resValid", 0, {31'd0, resValid});
        endTest();

        startTest("write and read-back");
        for (int i = 0; i < `NUM_ROWS; i++) begin
            writeRow(i, colDataT'($random(seed)));
        end
        for (int i = 0; i < `NUM_ROWS; i++) begin
            readRow(i);
        end
        endTest();

        startTest("compute against reference");
        for (int n = 0; n < numComputes; n++) begin
            computeCheck(randomAct());
        end
        endTest();

        startTest("strobes ignored while busy");
        row = `NUM_ROWS / 2 + 3;
        newData = ~shadow[row];
        act = randomAct();
        busyCycles = 0;
        pulses = 0;
        firstAt = 0;
        @(posedge CLK);
        #1;
        cmdValid = 1'b1;
        cmd = '0;
        cmd.op = CMD_COMPUTE;
        cmd.act = act;
        @(posedge CLK);
        #1;
        // Write strobe held through all busy cycles of the compute
        cmd.op = CMD_WRITE;
        cmd.row = rowAddrT'(row);
        cmd.wrData = newData;
        for (int k = 1; k <= 8; k++) begin
            @(negedge CLK);
            if (busy) begin
                busyCycles++;
            end
            if (resValid) begin
                pulses++;
                if (firstAt == 0) begin
                    firstAt = k;
                    resSnap = result;
                end
            end
            @(posedge CLK);
            #1;
            // Dropped before busy falls
            if (k == 3) begin
                cmdValid = 1'b0;
            end
        end
        checkValue("busy cycles of compute", 3, busyCycles);
        checkValue("resValid latency", 4, firstAt);
        checkValue("resValid pulse count", 1, pulses);
        for (int j = 0; j < `NUM_COLS; j++) begin
            checkValue($sformatf("result[%0d]", j), codeWord(expectedCode(j, act)),
                       codeWord(int'(resSnap[j])));
        end
        // Shadow untouched, so the old data is expected
        readRow(row);
        endTest();

        startTest("zero activations");
        act = '0;
        computeCheck(act);
        expectAll(0);
        // Code 10 also means zero
        for (int i = 0; i < `NUM_ROWS; i++) begin
            act[i] = ($random(seed) & 1) ? 2'b10 : 2'b00;
        end
        computeCheck(act);
        expectAll(0);
        endTest();

        startTest("saturation");
        for (int i = 0; i < `NUM_ROWS; i++) begin
            writeRow(i, '1);
        end
        for (int i = 0; i < `NUM_ROWS; i++) begin
            act[i] = 2'b01;
        end
        computeCheck(act);
        expectAll(adcHalf - 1);
        for (int i = 0; i < `NUM_ROWS; i++) begin
            act[i] = 2'b11;
        end
        computeCheck(act);
        expectAll(-adcHalf);
        endTest();

        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 testsRun, testsBad, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cimMacroTop.sv */
//##########################################################
// CIM macro tile
// Row driver, sequencer, column array and ADC decoder
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module cimMacroTop (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 cmdValid,
    input  cimCtrlPkg::cmdT      cmd,
    output logic                 busy,
    output logic                 rdValid,
    output cimDataPkg::colDataT  rdData,
    output logic                 resValid,
    output cimDataPkg::adcVecT   result
);
    import cimDataPkg::*;
    import cimCtrlPkg::*;

    // Array-side nets
    rowMaskT   wordLine;
    colDataT   wrData;
    smSelT     sel;
    phaseT     phase;
    colDataT   saOut;
    thermoArrT adcOut;

    rowDriver rowDriver_i (
        .CLK      (CLK),
        .rst      (rst),
        .cmdValid (cmdValid),
        .busy     (busy),
        .cmd      (cmd),
        .phase    (phase),
        .wordLine (wordLine),
        .wrData   (wrData),
        .sel      (sel)
    );

    macroSequencer macroSequencer_i (
        .CLK      (CLK),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .busy     (busy),
        .phase    (phase)
    );

    tsColumn tsColumn_i (
        .CLK      (CLK),
        .wordLine (wordLine),
        .wrData   (wrData),
        .phase    (phase),
        .sel      (sel),
        .saOut    (saOut),
        .adcOut   (adcOut)
    );

    adcDecoder adcDecoder_i (
        .CLK      (CLK),
        .rst      (rst),
        .phase    (phase),
        .saOut    (saOut),
        .adcOut   (adcOut),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .resValid (resValid),
        .result   (result)
    );

endmodule

`default_nettype wire

/* adcDecoder.sv */
//##########################################################
// ADC decoder
// Turns thermometer words into signed codes and registers
// sense data and compute results with valid pulses
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "cim_config.svh"

module adcDecoder (
    input  logic                   CLK,
    input  logic                   rst,
    input  cimCtrlPkg::phaseT      phase,
    input  cimDataPkg::colDataT    saOut,
    input  cimDataPkg::thermoArrT  adcOut,
    output logic                   rdValid,
    output cimDataPkg::colDataT    rdData,
    output logic                   resValid,
    output cimDataPkg::adcVecT     result
);
    import cimDataPkg::*;

    // Offset between comparator count and signed code
    localparam int adcHalf = 1 << (`NUM_ADC_BITS - 1);

    adcVecT decoded;

    // Ones count of each word, minus the mid-scale offset
    always_comb begin : thermoDecode
        int ones;
        for (int j = 0; j < `NUM_COLS; j++) begin
            ones = 0;
            for (int i = 0; i < `COMP_COUNT; i++) begin
                if (adcOut[j][i]) begin
                    ones = ones + 1;
                end
            end
            decoded[j] = adcCodeT'(ones - adcHalf);
        end
    end

    // One-cycle pulses after the sense and sample phases
    always_ff @(posedge CLK) begin : validRegs
        if (rst) begin
            rdValid  <= 1'b0;
            resValid <= 1'b0;
        end else begin
            rdValid  <= phase.saen;
            resValid <= phase.m2a;
        end
    end

    // Held until the next capture
    always_ff @(posedge CLK) begin : dataRegs
        if (phase.saen) begin
            rdData <= saOut;
        end
        if (phase.m2a) begin
            result <= decoded;
        end
    end

endmodule

`default_nettype wire

/* tsColumn.sv */
//##########################################################
// Ternary-weight SRAM column array
// Behavioral storage, sense read, bitline accumulation of
// the driven rows and a flash ADC per column
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "cim_config.svh"

module tsColumn (
    input  logic                   CLK,
    input  cimDataPkg::rowMaskT    wordLine,
    input  cimDataPkg::colDataT    wrData,
    input  cimCtrlPkg::phaseT      phase,
    input  cimCtrlPkg::smSelT      sel,
    output cimDataPkg::colDataT    saOut,
    output cimDataPkg::thermoArrT  adcOut
);
    import cimDataPkg::*;

    // Full-scale limits of the signed ADC code
    localparam int adcHalf = 1 << (`NUM_ADC_BITS - 1);
    localparam int adcMax  = adcHalf - 1;
    localparam int adcMin  = -adcHalf;

    // Bit 1 is weight +1, bit 0 is weight -1
    colDataT mem [`NUM_ROWS];

    logic signed [31:0] bitLine [`NUM_COLS];
    logic signed [31:0] level   [`NUM_COLS];
    thermoArrT          compOut;

    // Write needs the precharge held together with the write strobe
    always_ff @(posedge CLK) begin : sramWrite
        if (phase.pch && phase.write) begin
            for (int i = 0; i < `NUM_ROWS; i++) begin
                if (wordLine[i]) begin
                    mem[i] <= wrData;
                end
            end
        end
    end

    // Transparent sense amps read the row picked by the one-hot word line
    always_comb begin : senseRead
        saOut = '0;
        if (phase.pch && phase.saen) begin
            for (int i = 0; i < `NUM_ROWS; i++) begin
                if (wordLine[i]) begin
                    saOut = saOut | mem[i];
                end
            end
        end
    end

    // Charge sharing per column
    // a stored 1 sees the P matrix, a stored 0 the N matrix
    always_comb begin : bitlineSum
        for (int j = 0; j < `NUM_COLS; j++) begin
            bitLine[j] = '0;
            for (int i = 0; i < `NUM_ROWS; i++) begin
                if (mem[i][j]) begin
                    if (sel.pVdr[i]) begin
                        bitLine[j] = bitLine[j] + 1;
                    end
                    if (sel.pVss[i]) begin
                        bitLine[j] = bitLine[j] - 1;
                    end
                end else begin
                    if (sel.nVdr[i]) begin
                        bitLine[j] = bitLine[j] + 1;
                    end
                    if (sel.nVss[i]) begin
                        bitLine[j] = bitLine[j] - 1;
                    end
                end
                // Rows with no select sit at reset and add nothing
            end
        end
    end

    // Reference range narrowed by the shift, then clipped to full scale
    always_comb begin : rangeClamp
        for (int j = 0; j < `NUM_COLS; j++) begin
            level[j] = bitLine[j] >>> `NUM_ADC_REF_RANGE_SHIFTS;
            if (level[j] > adcMax) begin
                level[j] = adcMax;
            end else if (level[j] < adcMin) begin
                level[j] = adcMin;
            end
        end
    end

    // Comparator i trips once the offset code exceeds it
    always_comb begin : comparators
        for (int j = 0; j < `NUM_COLS; j++) begin
            for (int i = 0; i < `COMP_COUNT; i++) begin
                compOut[j][i] = (level[j] + adcHalf > i);
            end
        end
    end

    // Comparator word captured at the end of the drive phase
    // Held through SAMPLE so the decoder takes it on m2a
    always_ff @(posedge CLK) begin : compLatch
        if (phase.drive) begin
            adcOut <= compOut;
        end
    end

endmodule

`default_nettype wire

/* macroSequencer.sv */
//##########################################################
// Macro sequencer
// Command FSM producing the precharge, write, sense and
// ADC phase strobes together with the busy level
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module macroSequencer (
    input  logic               CLK,
    input  logic               rst,
    input  logic               cmdValid,
    input  cimCtrlPkg::cmdT    cmd,
    output logic               busy,
    output cimCtrlPkg::phaseT  phase
);
    import cimCtrlPkg::*;

    seqStateT state;
    seqStateT nextState;
    phaseT    nextPhase;

    // Commands only start from IDLE, so busy strobes never get here
    always_comb begin : nextStateLogic
        nextState = state;
        case (state)
            IDLE: begin
                if (cmdValid) begin
                    case (cmd.op)
                        CMD_WRITE:   nextState = WRITE;
                        CMD_READ:    nextState = SENSE;
                        CMD_COMPUTE: nextState = RESET_BL;
                        default:     nextState = IDLE;
                    endcase
                end
            end
            // Single-cycle memory accesses
            WRITE:    nextState = IDLE;
            SENSE:    nextState = IDLE;
            // Compute runs reset, drive, sample
            RESET_BL: nextState = DRIVE;
            DRIVE:    nextState = SAMPLE;
            SAMPLE:   nextState = IDLE;
            default:  nextState = IDLE;
        endcase
    end

    // Strobes follow the state being entered so they line up with it
    always_comb begin : phaseDecode
        nextPhase = '0;
        case (nextState)
            WRITE: begin
                nextPhase.pch   = 1'b1;
                nextPhase.write = 1'b1;
            end
            SENSE: begin
                nextPhase.pch  = 1'b1;
                nextPhase.saen = 1'b1;
            end
            // Bitlines back to reset level
            RESET_BL: nextPhase.r2a = 1'b1;
            DRIVE:    nextPhase.drive = 1'b1;
            // Converted code moves to the decoder
            SAMPLE:   nextPhase.m2a = 1'b1;
            default:  nextPhase = '0;
        endcase
    end

    always_ff @(posedge CLK) begin : stateReg
        if (rst) begin
            state <= IDLE;
            phase <= '0;
        end else begin
            state <= nextState;
            phase <= nextPhase;
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* rowDriver.sv */
//##########################################################
// Row driver
// Latches the accepted command, decodes the row address
// into word lines and maps activations to switch selects
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "cim_config.svh"

module rowDriver (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 cmdValid,
    input  logic                 busy,
    input  cimCtrlPkg::cmdT      cmd,
    input  cimCtrlPkg::phaseT    phase,
    output cimDataPkg::rowMaskT  wordLine,
    output cimDataPkg::colDataT  wrData,
    output cimCtrlPkg::smSelT    sel
);
    import cimDataPkg::*;

    rowAddrT rowReg;
    actVecT  actReg;
    rowMaskT rowOneHot;
    rowMaskT actPos;
    rowMaskT actNeg;
    logic    accept;

    // Strobes while busy are dropped
    assign accept = cmdValid && !busy;

    // Row and write data only matter once a phase enables them
    always_ff @(posedge CLK) begin : cmdLatch
        if (accept) begin
            rowReg <= cmd.row;
            wrData <= cmd.wrData;
        end
    end

    // Activations start at zero, i.e. every row at reset level
    always_ff @(posedge CLK) begin : actLatch
        if (rst) begin
            actReg <= '0;
        end else if (accept) begin
            actReg <= cmd.act;
        end
    end

    always_comb begin : rowDecode
        rowOneHot = '0;
        rowOneHot[rowReg] = 1'b1;
    end

    // Word line only open for write and sense
    assign wordLine = (phase.write || phase.saen) ? rowOneHot : '0;

    // Split codes into +1 and -1 row masks
    always_comb begin : actSplit
        for (int i = 0; i < `NUM_ROWS; i++) begin
            actPos[i] = (actReg[i] == 2'b01);
            actNeg[i] = (actReg[i] == 2'b11);
        end
    end

    // +1 pulls P side up and N side down, -1 the reverse
    always_comb begin : selDrive
        sel = '0;
        if (phase.drive) begin
            sel.pVdr = actPos;
            sel.nVss = actPos;
            sel.pVss = actNeg;
            sel.nVdr = actNeg;
        end
    end

endmodule

`default_nettype wire

/* cimCtrlPkg.sv */
//##########################################################
// CIM control types
// Command format, sequencer states, analog phase strobes
// and the switch-matrix select bundle
//##########################################################
`default_nettype none

package cimCtrlPkg;

    typedef enum logic [1:0] {
        CMD_WRITE   = 2'd0,
        CMD_READ    = 2'd1,
        CMD_COMPUTE = 2'd2
    } cmdOpT;

    // One command, row and data are don't-care for compute
    typedef struct packed {
        cmdOpT                op;
        cimDataPkg::rowAddrT  row;
        cimDataPkg::colDataT  wrData;
        cimDataPkg::actVecT   act;
    } cmdT;

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        SENSE,
        RESET_BL,
        DRIVE,
        SAMPLE
    } seqStateT;

    // Analog phase strobes, all active high
    typedef struct packed {
        logic pch;
        logic write;
        logic saen;
        logic r2a;
        logic m2a;
        logic drive;
    } phaseT;

    // Positive and negative switch-matrix selects per row
    typedef struct packed {
        cimDataPkg::rowMaskT pVdr;
        cimDataPkg::rowMaskT pVss;
        cimDataPkg::rowMaskT nVdr;
        cimDataPkg::rowMaskT nVss;
    } smSelT;

endpackage

`default_nettype wire

/* cimDataPkg.sv */
//##########################################################
// CIM data types
// Widths of rows, columns, activations, ADC codes and
// flash ADC thermometer words
//##########################################################
`default_nettype none

`include "cim_config.svh"

package cimDataPkg;

    // One bit per row, word lines and switch-matrix selects
    typedef logic [`NUM_ROWS-1:0] rowMaskT;

    // One bit per column, write data and sense output
    typedef logic [`NUM_COLS-1:0] colDataT;

    typedef logic [`ROW_ADDR_BITS-1:0] rowAddrT;

    // Activation code: 01 is +1, 11 is -1, 00 and 10 are 0
    typedef logic [1:0] actCodeT;
    typedef actCodeT [`NUM_ROWS-1:0] actVecT;

    // Signed ADC output code per column
    typedef logic signed [`NUM_ADC_BITS-1:0] adcCodeT;
    typedef adcCodeT [`NUM_COLS-1:0] adcVecT;

    // Comparator outputs of one column and of the whole tile
    typedef logic [`COMP_COUNT-1:0] thermoT;
    typedef thermoT [`NUM_COLS-1:0] thermoArrT;

endpackage

`default_nettype wire

/* cim_config.svh */
//##########################################################
// CIM tile configuration
// Array geometry, flash ADC resolution and the bitline
// reference-range shift shared by every block of the tile
//##########################################################
`ifndef CIM_CONFIG_SVH
`define CIM_CONFIG_SVH

// Array size, rows may be 16, 32 or 64
`define NUM_ROWS 32
`define NUM_COLS 8

// Flash ADC resolution in bits
`define NUM_ADC_BITS 4

// Reference range divided by 2**shift before conversion
`define NUM_ADC_REF_RANGE_SHIFTS 2

// Derived sizes
`define COMP_COUNT ((1 << `NUM_ADC_BITS) - 1)
`define ROW_ADDR_BITS $clog2(`NUM_ROWS)

`endif
